// ==== all.f ====
verilog/riscv_pkg.sv
verilog/core_pkg.sv
verilog/core_if.sv
verilog/frontend.sv
verilog/id_stage.sv
verilog/issue_stage.sv
verilog/ex_stage.sv
verilog/commit_stage.sv
verilog/mini_core.sv
dv/tb_mini_core.sv

// ==== Bender.yml ====
package:
  name: mini_core

sources:
  - verilog/riscv_pkg.sv
  - verilog/core_pkg.sv
  - verilog/core_if.sv
  - verilog/frontend.sv
  - verilog/id_stage.sv
  - verilog/issue_stage.sv
  - verilog/ex_stage.sv
  - verilog/commit_stage.sv
  - verilog/mini_core.sv
  - target: test
    files:
      - dv/tb_mini_core.sv

// ==== dv/tb_mini_core.sv ====
// testbench with clock, reset, program memory, golden model, directed tests and checks
module tb_mini_core;
  timeunit 1ns;
  timeprecision 100ps;
  import core_pkg::*;
  import riscv_pkg::*;

  logic                     clk_i;
  logic                     rst_ni;
  logic [XLEN-1:0]          boot_addr_i;
  logic                     instr_req;
  logic [XLEN-1:0]          instr_addr;
  logic [31:0]              instr_rdata;
  logic                     commit_valid;
  logic [XLEN-1:0]          commit_pc;
  logic                     commit_we;
  logic [REG_ADDR_BITS-1:0] commit_waddr;
  logic [XLEN-1:0]          commit_wdata;
  logic                     commit_illegal;

  // program image and the expected retire sequence
  logic [31:0]              prog_mem [64];
  int                       prog_len;
  logic [XLEN-1:0]          prog_base;
  logic [XLEN-1:0]          word_idx;
  logic [XLEN-1:0]          exp_pc [64];
  logic                     exp_we [64];
  logic [REG_ADDR_BITS-1:0] exp_rd [64];
  logic [XLEN-1:0]          exp_data [64];
  logic                     exp_ill [64];
  int                       exp_count;

  int          seed = 32'h7c5c_9b06;
  int unsigned reset_cycles = 16;
  int unsigned cycle_count = 0;
  int unsigned cycle_budget = 16;
  int          errors = 0;
  int          tests_run = 0;
  int          tests_failed = 0;

  mini_core mini_core_i (
    .clk_i            ( clk_i          ),
    .rst_ni           ( rst_ni         ),
    .boot_addr_i      ( boot_addr_i    ),
    .instr_req_o      ( instr_req      ),
    .instr_addr_o     ( instr_addr     ),
    .instr_rdata_i    ( instr_rdata    ),
    .commit_valid_o   ( commit_valid   ),
    .commit_pc_o      ( commit_pc      ),
    .commit_we_o      ( commit_we      ),
    .commit_waddr_o   ( commit_waddr   ),
    .commit_wdata_o   ( commit_wdata   ),
    .commit_illegal_o ( commit_illegal )
  );

  initial begin
    clk_i = 1'b0;
    forever #50 clk_i = ~clk_i;
  end

  // addi x0 with the whole address folded into its immediate fills the gaps
  function automatic logic [31:0] fill_word(logic [XLEN-1:0] addr);
    logic [11:0] fold;
    fold = addr[31:20] ^ addr[19:8] ^ {4'h0, addr[7:0]};
    return {fold, 13'b0, OPC_OP_IMM};
  endfunction

  // combinational instruction memory
  always_comb begin
    word_idx = (instr_addr - prog_base) >> 2;
    if (instr_addr >= prog_base && word_idx < prog_len) begin
      instr_rdata = prog_mem[word_idx];
    end else begin
      instr_rdata = fill_word(instr_addr);
    end
  end

  always @(posedge clk_i) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count > cycle_budget) begin
      $display("timeout after %0d cycles, the core stopped retiring", cycle_count);
      $display(">>> FAIL");
      $finish;
    end
  end

  // ------------------------------
  // compare tasks
  // ------------------------------
  task automatic check_pc(string test, logic [XLEN-1:0] exp_v, logic [XLEN-1:0] act_v);
    if (act_v !== exp_v) begin
      $display("CHECK FAILED %s: pc expected %h actual %h", test, exp_v, act_v);
      errors++;
    end
  endtask

  task automatic check_data(string test, logic [XLEN-1:0] exp_v, logic [XLEN-1:0] act_v);
    if (act_v !== exp_v) begin
      $display("CHECK FAILED %s: wdata expected %h actual %h", test, exp_v, act_v);
      errors++;
    end
  endtask

  task automatic check_reg(string test, logic [REG_ADDR_BITS-1:0] exp_v,
                           logic [REG_ADDR_BITS-1:0] act_v);
    if (act_v !== exp_v) begin
      $display("CHECK FAILED %s: waddr expected %0d actual %0d", test, exp_v, act_v);
      errors++;
    end
  endtask

  task automatic check_flag(string test, string what, logic exp_v, logic act_v);
    if (act_v !== exp_v) begin
      $display("CHECK FAILED %s: %s expected %b actual %b", test, what, exp_v, act_v);
      errors++;
    end
  endtask

  // ------------------------------
  // encoders and program build
  // ------------------------------
  function automatic logic [31:0] r_word(int f7, int f3, int rd, int rs1, int rs2);
    return {f7[6:0], rs2[4:0], rs1[4:0], f3[2:0], rd[4:0], OPC_OP};
  endfunction

  function automatic logic [31:0] i_word(int f3, int rd, int rs1, int imm);
    return {imm[11:0], rs1[4:0], f3[2:0], rd[4:0], OPC_OP_IMM};
  endfunction

  function automatic logic [31:0] u_word(int rd, int imm);
    return {imm[19:0], rd[4:0], OPC_LUI};
  endfunction

  function automatic logic [31:0] b_word(int f3, int rs1, int rs2, int off);
    return {off[12], off[10:5], rs2[4:0], rs1[4:0], f3[2:0], off[4:1], off[11], OPC_BRANCH};
  endfunction

  function automatic logic [XLEN-1:0] next_random();
    return $random(seed);
  endfunction

  task automatic emit(logic [31:0] w);
    prog_mem[prog_len] = w;
    prog_len++;
  endtask

  // lui plus addi with the upper part rounded for the sign of the low twelve bits
  task automatic load_const(int rd, logic [XLEN-1:0] value);
    logic [19:0] hi;
    hi = value[31:12] + {19'b0, value[11]};
    emit(u_word(rd, hi));
    emit(i_word(F3_ADD, rd, rd, value[11:0]));
  endtask

  task automatic start_program(logic [XLEN-1:0] base);
    @(posedge clk_i);
    rst_ni      <= 1'b0;
    boot_addr_i <= base;
    prog_base = base;
    prog_len  = 0;
  endtask

  // ------------------------------
  // golden isa model
  // ------------------------------
  task automatic golden_run();
    logic [XLEN-1:0] regs [NR_REGS];
    logic [XLEN-1:0] pc;
    logic [XLEN-1:0] next_pc;
    logic [XLEN-1:0] a;
    logic [XLEN-1:0] b;
    logic [XLEN-1:0] res;
    logic [31:0]     w;
    logic [2:0]      f3;
    logic [6:0]      f7;
    logic            we;
    logic            ill;
    int              i;
    for (i = 0; i < NR_REGS; i++) begin
      regs[i] = '0;
    end
    pc = prog_base;
    exp_count = 0;
    while (pc - prog_base < 4 * prog_len && exp_count < 64) begin
      w       = prog_mem[(pc - prog_base) >> 2];
      f3      = w[14:12];
      f7      = w[31:25];
      a       = regs[w[19:15]];
      b       = regs[w[24:20]];
      next_pc = pc + 4;
      we      = 1'b1;
      ill     = 1'b0;
      res     = '0;
      case (w[6:0])
        OPC_OP: begin
          ill = !((f7 == 7'h00 && f3 != 3'd3) || (f7 == F7_SUB && f3 == 3'd0));
          case (f3)
            3'd0:    res = (f7 == F7_SUB) ? a - b : a + b;
            3'd1:    res = a << b[4:0];
            3'd2:    res = {31'b0, $signed(a) < $signed(b)};
            3'd4:    res = a ^ b;
            3'd5:    res = a >> b[4:0];
            3'd6:    res = a | b;
            default: res = a & b;
          endcase
        end
        OPC_OP_IMM: begin
          ill = (f3 != 3'd0);
          res = a + {{20{w[31]}}, w[31:20]};
        end
        OPC_LUI: res = {w[31:12], 12'b0};
        OPC_BRANCH: begin
          we  = 1'b0;
          ill = (f3 > 3'd1);
          // beq takes on equal, bne on unequal
          if (!ill && ((a == b) != f3[0])) begin
            next_pc = pc + {{20{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
          end
        end
        default: ill = 1'b1;
      endcase
      if (ill || w[11:7] == 5'd0) begin
        we = 1'b0;
      end
      if (we) begin
        regs[w[11:7]] = res;
      end
      exp_pc[exp_count]   = pc;
      exp_we[exp_count]   = we;
      exp_rd[exp_count]   = w[11:7];
      exp_data[exp_count] = res;
      exp_ill[exp_count]  = ill;
      exp_count++;
      pc = next_pc;
    end
  endtask

  // release reset and compare every retirement in order
  task automatic run_program(string name);
    int n;
    int errs_before;
    cycle_budget += 40 * prog_len + reset_cycles;
    golden_run();
    errs_before = errors;
    repeat (reset_cycles - 1) @(posedge clk_i);
    rst_ni <= 1'b1;
    // first request goes out at the boot address
    @(negedge clk_i);
    check_flag(name, "instr_req", 1'b1, instr_req);
    check_pc(name, prog_base, instr_addr);
    n = 0;
    while (n < exp_count) begin
      @(negedge clk_i);
      if (commit_valid) begin
        check_pc(name, exp_pc[n], commit_pc);
        check_flag(name, "illegal", exp_ill[n], commit_illegal);
        check_flag(name, "we", exp_we[n], commit_we);
        if (exp_we[n]) begin
          check_reg(name, exp_rd[n], commit_waddr);
          check_data(name, exp_data[n], commit_wdata);
        end
        n++;
      end
    end
    tests_run++;
    if (errors != errs_before) begin
      tests_failed++;
    end
    $display("%s: %0d retired, %0d errors", name, n, errors - errs_before);
  endtask

  // ------------------------------
  // directed tests
  // ------------------------------
  task automatic alu_ops_test();
    start_program(32'h0000_1000);
    load_const(1, next_random());
    load_const(2, next_random());
    emit(r_word(0, F3_ADD, 10, 1, 2));
    emit(r_word(F7_SUB, F3_ADD, 11, 1, 2));
    emit(r_word(0, F3_AND, 12, 1, 2));
    emit(r_word(0, F3_OR, 13, 1, 2));
    emit(r_word(0, F3_XOR, 14, 1, 2));
    emit(r_word(0, F3_SLT, 15, 1, 2));
    emit(r_word(0, F3_SLT, 16, 2, 1));
    emit(r_word(0, F3_SLL, 17, 1, 2));
    emit(r_word(0, F3_SRL, 18, 1, 2));
    run_program("alu_ops");
  endtask

  task automatic immediates_test();
    start_program(32'h0000_2000);
    emit(i_word(F3_ADD, 5, 0, -1));
    emit(i_word(F3_ADD, 6, 5, -2048));
    emit(i_word(F3_ADD, 7, 6, 2047));
    emit(u_word(8, 20'hfffff));
    emit(u_word(9, 20'h80000));
    emit(i_word(F3_ADD, 9, 9, -1));
    // writes to x0 retire and leave it zero
    emit(i_word(F3_ADD, 0, 5, 5));
    emit(u_word(0, 20'habcde));
    emit(r_word(0, F3_ADD, 10, 0, 6));
    emit(i_word(F3_ADD, 11, 0, 0));
    run_program("immediates");
  endtask

  task automatic dependency_chain_test();
    start_program(32'h0000_3000);
    load_const(1, next_random());
    emit(i_word(F3_ADD, 2, 1, 3));
    emit(r_word(0, F3_ADD, 3, 2, 1));
    emit(r_word(F7_SUB, F3_ADD, 4, 3, 2));
    emit(r_word(0, F3_XOR, 5, 4, 3));
    emit(r_word(0, F3_SRL, 6, 5, 2));
    emit(i_word(F3_ADD, 6, 6, -7));
    emit(r_word(0, F3_OR, 7, 6, 1));
    emit(r_word(0, F3_SLL, 7, 7, 2));
    run_program("dependency_chain");
  endtask

  task automatic branches_test();
    start_program(32'h0000_4000);
    load_const(1, next_random());
    emit(i_word(F3_ADD, 2, 1, 0));
    emit(i_word(F3_ADD, 3, 1, 1));
    // taken beq over two words
    emit(b_word(F3_BEQ, 1, 2, 12));
    emit(i_word(F3_ADD, 10, 0, 1));
    emit(i_word(F3_ADD, 11, 0, 2));
    emit(i_word(F3_ADD, 12, 0, 3));
    emit(b_word(F3_BNE, 1, 2, 8));
    emit(i_word(F3_ADD, 13, 0, 4));
    // taken bne over two words
    emit(b_word(F3_BNE, 1, 3, 12));
    emit(i_word(F3_ADD, 14, 0, 5));
    emit(i_word(F3_ADD, 15, 0, 6));
    emit(i_word(F3_ADD, 16, 0, 7));
    emit(b_word(F3_BEQ, 1, 3, 8));
    emit(i_word(F3_ADD, 17, 0, 8));
    emit(r_word(0, F3_ADD, 18, 16, 12));
    run_program("branches");
  endtask

  task automatic illegal_test();
    start_program(32'h0000_5000);
    emit(i_word(F3_ADD, 1, 0, 5));
    emit(32'h0000_0000);
    emit(i_word(F3_ADD, 2, 1, 1));
    // sltu, mul and xori are outside the supported set
    emit(r_word(0, 3, 3, 1, 2));
    emit(r_word(1, F3_ADD, 4, 1, 2));
    emit(i_word(F3_XOR, 5, 2, 9));
    emit(i_word(F3_ADD, 6, 2, 1));
    emit(r_word(0, F3_ADD, 7, 6, 1));
    run_program("illegal");
  endtask

  task automatic boot_addr_test();
    start_program(32'h0000_7a30);
    emit(i_word(F3_ADD, 1, 0, 11));
    emit(u_word(2, 1));
    emit(r_word(0, F3_ADD, 3, 1, 2));
    run_program("boot_addr");
  endtask

  initial begin
    rst_ni      = 1'b0;
    boot_addr_i = '0;
    prog_base   = '0;
    prog_len    = 0;
    alu_ops_test();
    immediates_test();
    dependency_chain_test();
    branches_test();
    illegal_test();
    boot_addr_test();
    $display("%0d tests, %0d failed, %0d check errors", tests_run, tests_failed, errors);
    if (errors == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

endmodule

// ==== verilog/mini_core.sv ====
// top level wiring of the frontend, decode, issue, execute and commit stages
module mini_core (
  input  logic                               clk_i,
  input  logic                               rst_ni,
  input  logic [core_pkg::XLEN-1:0]          boot_addr_i,
  output logic                               instr_req_o,
  output logic [core_pkg::XLEN-1:0]          instr_addr_o,
  input  logic [31:0]                        instr_rdata_i,
  output logic                               commit_valid_o,
  output logic [core_pkg::XLEN-1:0]          commit_pc_o,
  output logic                               commit_we_o,
  output logic [core_pkg::REG_ADDR_BITS-1:0] commit_waddr_o,
  output logic [core_pkg::XLEN-1:0]          commit_wdata_o,
  output logic                               commit_illegal_o
);
  import core_pkg::*;

  // id <-> issue
  sb_entry_t                issue_entry;
  logic                     issue_valid;
  logic                     issue_ack;
  // issue <-> ex
  issued_t                  issued;
  logic                     issued_valid;
  // commit -> register file
  logic                     rf_we;
  logic [REG_ADDR_BITS-1:0] rf_waddr;
  logic [XLEN-1:0]          rf_wdata;

  fetch_if fetch ();
  wb_if    wb ();

  frontend frontend_i (
    .clk_i         ( clk_i         ),
    .rst_ni        ( rst_ni        ),
    .boot_addr_i   ( boot_addr_i   ),
    .instr_req_o   ( instr_req_o   ),
    .instr_addr_o  ( instr_addr_o  ),
    .instr_rdata_i ( instr_rdata_i ),
    .fetch         ( fetch         )
  );

  id_stage id_stage_i (
    .clk_i         ( clk_i       ),
    .rst_ni        ( rst_ni      ),
    .fetch         ( fetch       ),
    .issue_entry_o ( issue_entry ),
    .issue_valid_o ( issue_valid ),
    .issue_ack_i   ( issue_ack   )
  );

  issue_stage issue_stage_i (
    .clk_i          ( clk_i        ),
    .rst_ni         ( rst_ni       ),
    .entry_i        ( issue_entry  ),
    .valid_i        ( issue_valid  ),
    .ack_o          ( issue_ack    ),
    .flush_i        ( fetch.flush  ),
    .issued_o       ( issued       ),
    .issued_valid_o ( issued_valid ),
    .we_i           ( rf_we        ),
    .waddr_i        ( rf_waddr     ),
    .wdata_i        ( rf_wdata     )
  );

  ex_stage ex_stage_i (
    .clk_i    ( clk_i        ),
    .rst_ni   ( rst_ni       ),
    .issued_i ( issued       ),
    .valid_i  ( issued_valid ),
    .fetch    ( fetch        ),
    .wb       ( wb           )
  );

  commit_stage commit_stage_i (
    .clk_i            ( clk_i            ),
    .rst_ni           ( rst_ni           ),
    .wb               ( wb               ),
    .we_o             ( rf_we            ),
    .waddr_o          ( rf_waddr         ),
    .wdata_o          ( rf_wdata         ),
    .commit_valid_o   ( commit_valid_o   ),
    .commit_pc_o      ( commit_pc_o      ),
    .commit_we_o      ( commit_we_o      ),
    .commit_waddr_o   ( commit_waddr_o   ),
    .commit_wdata_o   ( commit_wdata_o   ),
    .commit_illegal_o ( commit_illegal_o )
  );

endmodule

// ==== verilog/commit_stage.sv ====
// commit stage: register write-back and retire trace outputs
module commit_stage (
  input  logic                               clk_i,
  input  logic                               rst_ni,
  wb_if.commit                               wb,
  output logic                               we_o,
  output logic [core_pkg::REG_ADDR_BITS-1:0] waddr_o,
  output logic [core_pkg::XLEN-1:0]          wdata_o,
  output logic                               commit_valid_o,
  output logic [core_pkg::XLEN-1:0]          commit_pc_o,
  output logic                               commit_we_o,
  output logic [core_pkg::REG_ADDR_BITS-1:0] commit_waddr_o,
  output logic [core_pkg::XLEN-1:0]          commit_wdata_o,
  output logic                               commit_illegal_o
);
  import core_pkg::*;

  logic                     valid_q;
  logic                     we_q;
  logic [REG_ADDR_BITS-1:0] waddr_q;
  logic [XLEN-1:0]          wdata_q;
  logic [XLEN-1:0]          pc_q;
  logic                     illegal_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q <= 1'b0;
      we_q    <= 1'b0;
    end else begin
      valid_q <= wb.valid;
      // x0 writes retire without touching the register file
      we_q    <= wb.valid & wb.writes_rd & (wb.rd != '0);
    end
  end

  always_ff @(posedge clk_i) begin
    waddr_q   <= wb.rd;
    wdata_q   <= wb.wdata;
    pc_q      <= wb.pc;
    illegal_q <= wb.illegal;
  end

  // ------------------------------
  // write-back and trace
  // ------------------------------
  assign we_o    = we_q;
  assign waddr_o = waddr_q;
  assign wdata_o = wdata_q;

  assign commit_valid_o   = valid_q;
  assign commit_pc_o      = pc_q;
  assign commit_we_o      = we_q;
  assign commit_waddr_o   = waddr_q;
  assign commit_wdata_o   = wdata_q;
  assign commit_illegal_o = valid_q & illegal_q;

endmodule

// ==== verilog/ex_stage.sv ====
// execute stage alu, branch compare and resolution, and the result register
module ex_stage (
  input  logic              clk_i,
  input  logic              rst_ni,
  input  core_pkg::issued_t issued_i,
  input  logic              valid_i,
  fetch_if.execute          fetch,
  wb_if.execute             wb
);
  import core_pkg::*;

  logic [XLEN-1:0]  op_a;
  logic [XLEN-1:0]  op_b;
  logic [XLEN-1:0]  result;
  resolved_branch_t redirect_q;

  assign op_a = issued_i.operand_a;
  assign op_b = issued_i.sbe.use_imm ? issued_i.sbe.imm : issued_i.operand_b;

  // ------------------------------
  // alu
  // ------------------------------
  always_comb begin
    unique case (issued_i.sbe.op)
      ALU_ADD: result = op_a + op_b;
      ALU_SUB: result = op_a - op_b;
      ALU_AND: result = op_a & op_b;
      ALU_OR:  result = op_a | op_b;
      ALU_XOR: result = op_a ^ op_b;
      ALU_SLT: result = XLEN'($signed(op_a) < $signed(op_b));
      ALU_SLL: result = op_a << op_b[4:0];
      ALU_SRL: result = op_a >> op_b[4:0];
      ALU_LUI: result = op_b;
      ALU_EQ:  result = XLEN'(op_a == op_b);
      ALU_NE:  result = XLEN'(op_a != op_b);
      default: result = '0;
    endcase
  end

  // flush follows one cycle after the branch resolves
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      redirect_q <= '0;
    end else begin
      redirect_q.valid  <= valid_i & issued_i.sbe.is_branch;
      redirect_q.taken  <= result[0];
      redirect_q.target <= issued_i.sbe.pc + issued_i.sbe.imm;
    end
  end

  assign fetch.redirect = redirect_q;
  assign fetch.flush    = redirect_q.valid & redirect_q.taken;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wb.valid <= 1'b0;
    end else begin
      wb.valid <= valid_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (valid_i) begin
      wb.rd        <= issued_i.sbe.rd;
      wb.wdata     <= result;
      wb.writes_rd <= issued_i.sbe.writes_rd;
      wb.pc        <= issued_i.sbe.pc;
      wb.illegal   <= issued_i.sbe.illegal;
    end
  end

endmodule

// ==== verilog/issue_stage.sv ====
// issue stage: register file, busy scoreboard, operand read and hazard stall
module issue_stage (
  input  logic                               clk_i,
  input  logic                               rst_ni,
  input  core_pkg::sb_entry_t                entry_i,
  input  logic                               valid_i,
  output logic                               ack_o,
  input  logic                               flush_i,
  output core_pkg::issued_t                  issued_o,
  output logic                               issued_valid_o,
  input  logic                               we_i,
  input  logic [core_pkg::REG_ADDR_BITS-1:0] waddr_i,
  input  logic [core_pkg::XLEN-1:0]          wdata_i
);
  import core_pkg::*;

  logic [XLEN-1:0]    rf_q [NR_REGS];
  logic [NR_REGS-1:0] busy_q;
  logic               hazard;
  logic               sets_busy;

  // ------------------------------
  // hazard check
  // ------------------------------
  // x0 is never marked busy, so unused sources decoded as x0 pass.
  // a busy rd also holds, so an older write cannot clear a newer busy bit
  assign hazard = busy_q[entry_i.rs1] | busy_q[entry_i.rs2]
                | (entry_i.writes_rd & busy_q[entry_i.rd]);

  assign ack_o          = ~hazard;
  // the instruction behind a taken branch is dropped here
  assign issued_valid_o = valid_i & ~hazard & ~flush_i;
  assign sets_busy      = issued_valid_o & entry_i.writes_rd & (entry_i.rd != '0);

  // operand read, x0 reads zero
  always_comb begin
    issued_o.sbe       = entry_i;
    issued_o.operand_a = (entry_i.rs1 == '0) ? '0 : rf_q[entry_i.rs1];
    issued_o.operand_b = (entry_i.rs2 == '0) ? '0 : rf_q[entry_i.rs2];
  end

  // ------------------------------
  // register file
  // ------------------------------
  always_ff @(posedge clk_i) begin
    if (we_i && waddr_i != '0) begin
      rf_q[waddr_i] <= wdata_i;
    end
  end

  // set on issue wins over clear on commit
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      busy_q <= '0;
    end else begin
      if (we_i) begin
        busy_q[waddr_i] <= 1'b0;
      end
      if (sets_busy) begin
        busy_q[entry_i.rd] <= 1'b1;
      end
    end
  end

endmodule

// ==== verilog/id_stage.sv ====
// decode stage: instruction decode into a scoreboard entry, illegal check
module id_stage (
  input  logic                clk_i,
  input  logic                rst_ni,
  fetch_if.decode             fetch,
  output core_pkg::sb_entry_t issue_entry_o,
  output logic                issue_valid_o,
  input  logic                issue_ack_i
);
  import core_pkg::*;
  import riscv_pkg::*;

  logic [31:0] instr;
  opcode_e     opcode;
  funct3_e     funct3;
  logic [6:0]  funct7;
  sb_entry_t   decoded;
  sb_entry_t   entry_q;
  logic        valid_q;

  assign instr  = fetch.entry.instr;
  assign opcode = opcode_e'(instr[6:0]);
  assign funct3 = funct3_e'(instr[FUNCT3_POS +: 3]);
  assign funct7 = instr[FUNCT7_POS +: 7];

  always_comb begin
    decoded           = '0;
    decoded.pc        = fetch.entry.pc;
    decoded.op        = ALU_ADD;
    decoded.rd        = instr[RD_POS +: REG_ADDR_BITS];
    decoded.rs1       = instr[RS1_POS +: REG_ADDR_BITS];
    decoded.rs2       = instr[RS2_POS +: REG_ADDR_BITS];
    decoded.writes_rd = 1'b1;
    unique case (opcode)
      OPC_OP: begin
        unique case (funct3)
          F3_ADD:  decoded.op = (funct7 == F7_SUB) ? ALU_SUB : ALU_ADD;
          F3_SLL:  decoded.op = ALU_SLL;
          F3_SLT:  decoded.op = ALU_SLT;
          F3_XOR:  decoded.op = ALU_XOR;
          F3_SRL:  decoded.op = ALU_SRL;
          F3_OR:   decoded.op = ALU_OR;
          F3_AND:  decoded.op = ALU_AND;
          default: decoded.illegal = 1'b1;
        endcase
        // only sub carries a non-zero funct7
        if (funct7 != '0 && !(funct7 == F7_SUB && funct3 == F3_ADD)) begin
          decoded.illegal = 1'b1;
        end
      end
      OPC_OP_IMM: begin
        // addi only
        decoded.rs2     = '0;
        decoded.use_imm = 1'b1;
        decoded.imm     = {{20{instr[31]}}, instr[IMM_I_POS +: 12]};
        decoded.illegal = (funct3 != F3_ADD);
      end
      OPC_LUI: begin
        decoded.op      = ALU_LUI;
        decoded.rs1     = '0;
        decoded.rs2     = '0;
        decoded.use_imm = 1'b1;
        decoded.imm     = {instr[31:IMM_U_POS], 12'b0};
      end
      OPC_BRANCH: begin
        decoded.rd        = '0;
        decoded.writes_rd = 1'b0;
        decoded.is_branch = 1'b1;
        decoded.imm       = {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
        unique case (funct3)
          F3_BEQ:  decoded.op = ALU_EQ;
          F3_BNE:  decoded.op = ALU_NE;
          default: decoded.illegal = 1'b1;
        endcase
      end
      default: decoded.illegal = 1'b1;
    endcase
    // an illegal word reads and writes nothing
    if (decoded.illegal) begin
      decoded.rs1       = '0;
      decoded.rs2       = '0;
      decoded.rd        = '0;
      decoded.writes_rd = 1'b0;
      decoded.is_branch = 1'b0;
    end
  end

  // accept when empty or when issue takes the current entry
  assign fetch.ack     = ~valid_q | issue_ack_i;
  assign issue_entry_o = entry_q;
  assign issue_valid_o = valid_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q <= 1'b0;
    end else if (fetch.flush) begin
      valid_q <= 1'b0;
    end else if (fetch.ack) begin
      valid_q <= fetch.valid;
    end
  end

  always_ff @(posedge clk_i) begin
    if (fetch.ack && fetch.valid) begin
      entry_q <= decoded;
    end
  end

endmodule

// ==== verilog/frontend.sv ====
// frontend with pc generation, instruction request and the fetch entry register
module frontend (
  input  logic                      clk_i,
  input  logic                      rst_ni,
  input  logic [core_pkg::XLEN-1:0] boot_addr_i,
  output logic                      instr_req_o,
  output logic [core_pkg::XLEN-1:0] instr_addr_o,
  input  logic [31:0]               instr_rdata_i,
  fetch_if.frontend                 fetch
);
  import core_pkg::*;
  import riscv_pkg::*;

  logic [XLEN-1:0] pc_q;
  logic            valid_q;

  // request whenever the entry register is free or drains this cycle
  assign instr_req_o  = ~valid_q | fetch.ack;
  assign instr_addr_o = pc_q;
  assign fetch.valid  = valid_q;

  // ------------------------------
  // pc and fetch entry
  // ------------------------------
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      pc_q        <= boot_addr_i;
      valid_q     <= 1'b0;
      fetch.entry <= '{pc: boot_addr_i, instr: NOP_INSTR};
    end else if (fetch.flush) begin
      // taken branch, restart at the target
      pc_q    <= fetch.redirect.target;
      valid_q <= 1'b0;
    end else if (instr_req_o) begin
      pc_q        <= pc_q + XLEN'(4);
      valid_q     <= 1'b1;
      fetch.entry <= '{pc: pc_q, instr: instr_rdata_i};
    end
  end

endmodule

// ==== verilog/core_if.sv ====
// fetch_if and wb_if interfaces with their modports

// frontend to decode handshake, plus the branch flush from execute
interface fetch_if;
  import core_pkg::*;

  logic             valid;
  fetch_entry_t     entry;
  logic             ack;
  logic             flush;
  resolved_branch_t redirect;

  modport frontend (
    output valid, entry,
    input  ack, flush, redirect
  );

  modport decode (
    input  valid, entry, flush,
    output ack
  );

  modport execute (
    output flush, redirect
  );

endinterface

// registered outcome of execute, consumed by commit
interface wb_if;
  import core_pkg::*;

  logic                     valid;
  logic [REG_ADDR_BITS-1:0] rd;
  logic [XLEN-1:0]          wdata;
  logic                     writes_rd;
  logic [XLEN-1:0]          pc;
  logic                     illegal;

  modport execute (output valid, rd, wdata, writes_rd, pc, illegal);

  modport commit (input valid, rd, wdata, writes_rd, pc, illegal);

endinterface

// ==== verilog/core_pkg.sv ====
// pipeline widths, alu op enum, fetch entry, scoreboard entry and branch structs
package core_pkg;

  localparam int unsigned XLEN          = 32;
  localparam int unsigned NR_REGS       = 32;
  localparam int unsigned REG_ADDR_BITS = 5;

  typedef enum logic [3:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_AND,
    ALU_OR,
    ALU_XOR,
    ALU_SLT,
    ALU_SLL,
    ALU_SRL,
    ALU_LUI,
    ALU_EQ,
    ALU_NE
  } alu_op_e;

  typedef struct packed {
    logic [XLEN-1:0] pc;
    logic [31:0]     instr;
  } fetch_entry_t;

  // decoded instruction as it leaves the decode stage
  typedef struct packed {
    logic [XLEN-1:0]          pc;
    alu_op_e                  op;
    logic [REG_ADDR_BITS-1:0] rs1;
    logic [REG_ADDR_BITS-1:0] rs2;
    logic [REG_ADDR_BITS-1:0] rd;
    logic [XLEN-1:0]          imm;
    logic                     use_imm;
    logic                     is_branch;
    logic                     writes_rd;
    logic                     illegal;
  } sb_entry_t;

  typedef struct packed {
    sb_entry_t       sbe;
    logic [XLEN-1:0] operand_a;
    logic [XLEN-1:0] operand_b;
  } issued_t;

  typedef struct packed {
    logic            valid;
    logic            taken;
    logic [XLEN-1:0] target;
  } resolved_branch_t;

endpackage

// ==== verilog/riscv_pkg.sv ====
// rv32i opcode and funct3 encodings, instruction field positions, nop word
package riscv_pkg;

  // major opcodes handled by the core
  typedef enum logic [6:0] {
    OPC_OP     = 7'b0110011,
    OPC_OP_IMM = 7'b0010011,
    OPC_LUI    = 7'b0110111,
    OPC_BRANCH = 7'b1100011
  } opcode_e;

  typedef enum logic [2:0] {
    F3_ADD = 3'b000,
    F3_SLL = 3'b001,
    F3_SLT = 3'b010,
    F3_XOR = 3'b100,
    F3_SRL = 3'b101,
    F3_OR  = 3'b110,
    F3_AND = 3'b111
  } funct3_e;

  // branch compares share the funct3 space with the alu codes
  localparam funct3_e F3_BEQ = F3_ADD;
  localparam funct3_e F3_BNE = F3_SLL;

  localparam logic [6:0] F7_SUB = 7'b0100000;

  // ------------------------------
  // field positions (lsb)
  // ------------------------------
  localparam int unsigned RD_POS     = 7;
  localparam int unsigned FUNCT3_POS = 12;
  localparam int unsigned RS1_POS    = 15;
  localparam int unsigned RS2_POS    = 20;
  localparam int unsigned FUNCT7_POS = 25;
  localparam int unsigned IMM_I_POS  = 20;
  localparam int unsigned IMM_U_POS  = 12;

  // addi x0, x0, 0
  localparam logic [31:0] NOP_INSTR = 32'h0000_0013;

endpackage
